// File: Bender.yml
package:
  name: mem_subsys

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - verilog/lsu_pkg.sv
      - verilog/dbus_pkg.sv
      - verilog/store_align.sv
      - verilog/load_align.sv
      - verilog/mem_stage.sv
      - verilog/data_ram.sv
      - verilog/mem_subsys_top.sv

  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_mem_subsys.sv

// File: dv/tb_clk_gen.sv
// testbench clock and reset source for the memory subsystem
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic arst_n_o
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // released on a falling edge, away from the capture edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n_o = 1'b1;
  end

endmodule

// File: dv/tb_mem_subsys.sv
// testbench for the memory subsystem with random loads and stores against a byte-array model
`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int RAM_WORDS      = 256;
  localparam int RESP_DELAY     = 2;
  localparam int NUM_OPS        = 400;
  localparam int DIRECTED_OPS   = 34; // reset loads plus the lane sweep
  localparam int SWEEP_WORD     = 5;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (RESP_DELAY + 6) + 50;

  logic               clk;
  logic               arst_n;
  logic               load;
  dbus_pkg::strb_t    store_mask;
  dbus_pkg::addr_t    addr;
  lsu_pkg::xlen_t     wdata;
  lsu_pkg::acc_size_e size;
  logic               sext;
  logic               stall;
  lsu_pkg::xlen_t     rdata;
  logic               rdata_valid;

  // reference memory with one entry per byte
  logic [7:0] model_mem [RAM_WORDS*8];

  // request presented to the stage
  logic               cur_store;
  logic               cur_load_too;
  lsu_pkg::acc_size_e cur_size;
  logic               cur_sext;
  dbus_pkg::addr_t    cur_addr;
  lsu_pkg::xlen_t     cur_data;

  lsu_pkg::xlen_t exp_q [$]; // load results still owed by the DUT
  int             accepted;
  int             loads_issued;
  int             pulses;
  int             completions;
  int             gap_left;
  logic           presenting;
  logic           stall_prev;
  logic           rise_due;
  int unsigned    cycle_cnt = 0;

  tb_clk_gen #(
    .PERIOD_NS  (100),
    .RST_CYCLES (3)
  ) u_clk_gen (
    .clk      (clk),
    .arst_n_o (arst_n)
  );

  mem_subsys_top #(
    .RAM_WORDS  (RAM_WORDS),
    .RESP_DELAY (RESP_DELAY)
  ) dut_i (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .load_i        (load),
    .store_mask_i  (store_mask),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .size_i        (size),
    .sext_i        (sext),
    .stall_o       (stall),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_load(input lsu_pkg::xlen_t exp, input lsu_pkg::xlen_t act);
    if (act !== exp) begin
      fail_run($sformatf("FAILED rdata_o: expected %h, actual %h", exp, act));
    end
  endtask

  task automatic check_stall(input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("FAILED stall_o: expected %h, actual %h", exp, act));
    end
  endtask

  task automatic check_valid(input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("FAILED rdata_valid_o: expected %h, actual %h", exp, act));
    end
  endtask

  function automatic dbus_pkg::strb_t low_mask(input lsu_pkg::acc_size_e sz);
    return 8'hff >> (8 - (1 << sz));
  endfunction

  task automatic model_store(input dbus_pkg::addr_t a, input lsu_pkg::acc_size_e sz,
                             input lsu_pkg::xlen_t d);
    int base;
    base = int'(a);
    for (int k = 0; k < (1 << sz); k++) begin
      model_mem[base + k] = d[8*k +: 8];
    end
  endtask

  function automatic lsu_pkg::xlen_t model_load(input dbus_pkg::addr_t a,
                                                input lsu_pkg::acc_size_e sz, input logic sx);
    int             base;
    int             nbytes;
    lsu_pkg::xlen_t val;
    base   = int'(a);
    nbytes = 1 << sz;
    val    = '0;
    for (int k = 0; k < nbytes; k++) begin
      val[8*k +: 8] = model_mem[base + k];
    end
    if (sx && nbytes < 8 && val[8*nbytes-1]) begin
      for (int k = nbytes; k < 8; k++) begin
        val[8*k +: 8] = 8'hff; // negative value
      end
    end
    return val;
  endfunction

  // op n picks reset loads, then a store/readback sweep of one word, then random ones
  task automatic pick_op(input int n);
    int pair;
    int word;
    int off;
    cur_data     = {$urandom, $urandom};
    cur_sext     = 1'($urandom_range(1));
    cur_load_too = 1'b0;
    if (n < 4) begin
      cur_store = 1'b0;
      cur_size  = lsu_pkg::size_d;
      word      = $urandom_range(RAM_WORDS - 1);
      off       = 0;
    end else if (n < DIRECTED_OPS) begin
      pair      = (n - 4) / 2;
      cur_store = ((n - 4) % 2 == 0);
      word      = SWEEP_WORD;
      if (pair < 8) begin
        cur_size = lsu_pkg::size_b;
        off      = pair;
      end else if (pair < 12) begin
        cur_size = lsu_pkg::size_h;
        off      = (pair - 8) * 2;
      end else if (pair < 14) begin
        cur_size = lsu_pkg::size_w;
        off      = (pair - 12) * 4;
      end else begin
        cur_size = lsu_pkg::size_d;
        off      = 0;
      end
      if (!cur_store) begin
        cur_size = lsu_pkg::size_d; // whole word readback
        off      = 0;
      end
    end else begin
      cur_store    = 1'($urandom_range(1));
      cur_load_too = cur_store && ($urandom_range(3) == 0);
      cur_size     = lsu_pkg::acc_size_e'($urandom_range(3));
      // mostly a small window so loads find stored data
      word = ($urandom_range(3) == 0) ? $urandom_range(RAM_WORDS - 1) : $urandom_range(7);
      off  = $urandom_range(7) & ~((1 << cur_size) - 1);
    end
    cur_addr = dbus_pkg::addr_t'(word * 8 + off);
  endtask

  task automatic drive_op();
    load       <= cur_store ? cur_load_too : 1'b1;
    store_mask <= cur_store ? low_mask(cur_size) : 8'h00;
    addr       <= cur_addr;
    wdata      <= cur_data;
    size       <= cur_size;
    sext       <= cur_sext;
  endtask

  task automatic drive_idle();
    load       <= 1'b0;
    store_mask <= 8'h00;
  endtask

  // request seen with stall low at the falling edge is taken on the next rising edge
  task automatic take_op();
    if (exp_q.size() != 0) begin
      fail_run("a load completed without an rdata_valid_o pulse");
    end else begin
      if (cur_store) begin
        model_store(cur_addr, cur_size, cur_data);
      end else begin
        exp_q.push_back(model_load(cur_addr, cur_size, cur_sext));
        loads_issued++;
      end
      accepted++;
      rise_due = 1'b1;
      gap_left = ($urandom_range(3) == 0) ? int'($urandom_range(RESP_DELAY + 4)) : 0;
      if (accepted < NUM_OPS) begin
        pick_op(accepted);
      end
    end
  endtask

  task automatic watch_outputs();
    if (rise_due) begin
      check_stall(1'b1, stall);
      rise_due = 1'b0;
    end
    if (stall_prev && !stall) begin
      completions++;
    end
    if (rdata_valid) begin
      if (exp_q.size() == 0) begin
        fail_run("rdata_valid_o pulsed with no load outstanding");
      end else begin
        check_stall(1'b0, stall); // pulse comes with the stall fall
        check_load(exp_q.pop_front(), rdata);
        pulses++;
      end
    end
    stall_prev = stall;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      fail_run($sformatf("run hung: only %0d of %0d operations done after %0d cycles",
                         completions, NUM_OPS, cycle_cnt));
    end
  end

  initial begin
    void'($urandom(32'hc607));
    load         = 1'b0;
    store_mask   = 8'h00;
    addr         = '0;
    wdata        = '0;
    size         = lsu_pkg::size_b;
    sext         = 1'b0;
    accepted     = 0;
    loads_issued = 0;
    pulses       = 0;
    completions  = 0;
    gap_left     = 0;
    presenting   = 1'b0;
    rise_due     = 1'b0;
    for (int i = 0; i < RAM_WORDS * 8; i++) begin
      model_mem[i] = 8'h00;
    end
    wait (arst_n === 1'b1);
    @(negedge clk);
    check_stall(1'b0, stall);
    check_valid(1'b0, rdata_valid);
    stall_prev = stall;
    pick_op(0);

    while (accepted < NUM_OPS) begin
      @(posedge clk);
      if (gap_left > 0) begin
        drive_idle();
        gap_left--;
        presenting = 1'b0;
      end else begin
        // swap the held request now and then since a stalled one leaves no trace
        if (stall_prev && accepted >= DIRECTED_OPS && $urandom_range(2) == 0) begin
          pick_op(accepted);
        end
        drive_op();
        presenting = 1'b1;
      end
      @(negedge clk);
      watch_outputs();
      if (presenting && !stall) begin
        take_op();
      end
    end

    @(posedge clk);
    drive_idle();
    while (completions < NUM_OPS) begin
      @(negedge clk);
      watch_outputs();
    end
    repeat (RESP_DELAY + 4) begin
      @(negedge clk);
      watch_outputs(); // no stray pulses after the last op
    end

    if (pulses != loads_issued) begin
      fail_run($sformatf("saw %0d load pulses for %0d loads", pulses, loads_issued));
    end else if (completions != accepted) begin
      fail_run($sformatf("%0d operations completed, %0d issued", completions, accepted));
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: tb.f
verilog/lsu_pkg.sv
verilog/dbus_pkg.sv
verilog/store_align.sv
verilog/load_align.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/mem_subsys_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_subsys.sv

// File: verilog/data_ram.sv
// data RAM bus slave: one read or write at a time with a fixed response delay
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 2 // at least 1
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            w_req_valid_i,
  output logic            w_req_ready_o,
  input  dbus_pkg::addr_t w_addr_i,
  input  lsu_pkg::xlen_t  w_data_i,
  input  dbus_pkg::strb_t w_strb_i,
  output logic            w_resp_valid_o,
  input  logic            w_resp_ready_i,
  input  logic            r_req_valid_i,
  output logic            r_req_ready_o,
  input  dbus_pkg::addr_t r_addr_i,
  output logic            r_resp_valid_o,
  output lsu_pkg::xlen_t  r_data_o,
  input  logic            r_resp_ready_i
);

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RESP_DELAY + 1);

  lsu_pkg::xlen_t       mem_q [RAM_WORDS];
  dbus_pkg::ram_state_e state_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 is_write_q;
  logic [IDX_W-1:0]     idx_q;
  lsu_pkg::xlen_t       wdata_q;
  dbus_pkg::strb_t      strb_q;
  lsu_pkg::xlen_t       rdata_q;
  logic                 w_acc;
  logic                 r_acc;

  assign w_acc = w_req_valid_i && w_req_ready_o;
  assign r_acc = r_req_valid_i && r_req_ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= dbus_pkg::ram_idle;
      cnt_q      <= '0;
      is_write_q <= 1'b0;
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      unique case (state_q)
        dbus_pkg::ram_idle: begin
          if (w_acc || r_acc) begin
            state_q    <= dbus_pkg::ram_wait;
            cnt_q      <= CNT_W'(RESP_DELAY - 1);
            is_write_q <= w_acc;
          end
        end
        dbus_pkg::ram_wait: begin
          if (cnt_q == '0) begin
            state_q <= dbus_pkg::ram_resp;
            if (is_write_q) begin
              for (int b = 0; b < 8; b++) begin
                if (strb_q[b]) mem_q[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
              end
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          if ((w_resp_valid_o && w_resp_ready_i) || (r_resp_valid_o && r_resp_ready_i)) begin
            state_q <= dbus_pkg::ram_idle;
          end
        end
      endcase
    end
  end

  // request payload and read word
  always_ff @(posedge clk) begin
    if (w_acc) begin
      idx_q   <= w_addr_i[3 +: IDX_W];
      wdata_q <= w_data_i;
      strb_q  <= w_strb_i;
    end else if (r_acc) begin
      idx_q <= r_addr_i[3 +: IDX_W];
    end
    if (state_q == dbus_pkg::ram_wait && cnt_q == '0 && !is_write_q) begin
      rdata_q <= mem_q[idx_q];
    end
  end

  assign w_req_ready_o  = (state_q == dbus_pkg::ram_idle);
  assign r_req_ready_o  = (state_q == dbus_pkg::ram_idle) && !w_req_valid_i; // writes first
  assign w_resp_valid_o = (state_q == dbus_pkg::ram_resp) && is_write_q;
  assign r_resp_valid_o = (state_q == dbus_pkg::ram_resp) && !is_write_q;
  assign r_data_o       = rdata_q;

  addr_range_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    (w_acc |-> w_addr_i[63:3] < RAM_WORDS) and (r_acc |-> r_addr_i[63:3] < RAM_WORDS))
    else $error("data RAM access beyond %0d words", RAM_WORDS);

endmodule

// File: verilog/dbus_pkg.sv
// data bus definitions: address and strobe widths, slave state encoding
package dbus_pkg;

  localparam int ADDR_W = 64;
  localparam int STRB_W = 8;  // one strobe bit per byte lane

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t;

  // slave side sequencing
  typedef enum logic [1:0] {
    ram_idle = 2'd0, // ready for a new request
    ram_wait = 2'd1, // counting out the response delay
    ram_resp = 2'd2  // response valid, waiting for ready
  } ram_state_e;

endpackage

// File: verilog/load_align.sv
// load extraction: picks the addressed lanes from a read word and extends them
`timescale 1ns/1ps

module load_align (
  input  logic [2:0]         addr_lo_i,
  input  lsu_pkg::xlen_t     word_i,
  input  lsu_pkg::acc_size_e size_i,
  input  logic               sext_i,
  output lsu_pkg::xlen_t     data_o
);

  logic [5:0]     bit_shift;
  lsu_pkg::xlen_t shifted;
  logic           fill;

  assign bit_shift = {addr_lo_i, 3'b000};
  assign shifted   = word_i >> bit_shift; // addressed byte now in lane 0

  // top kept bit, or zero for unsigned loads
  always_comb begin
    unique case (size_i)
      lsu_pkg::size_b: fill = sext_i & shifted[7];
      lsu_pkg::size_h: fill = sext_i & shifted[15];
      lsu_pkg::size_w: fill = sext_i & shifted[31];
      default:         fill = 1'b0;
    endcase
  end

  always_comb begin
    unique case (size_i)
      lsu_pkg::size_b: begin
        data_o = {{56{fill}}, shifted[7:0]};
      end
      lsu_pkg::size_h: begin
        data_o = {{48{fill}}, shifted[15:0]};
      end
      lsu_pkg::size_w: begin
        data_o = {{32{fill}}, shifted[31:0]};
      end
      default: begin
        data_o = shifted; // full word, nothing to extend
      end
    endcase
  end

endmodule

// File: verilog/lsu_pkg.sv
// load/store unit types: data word, access sizes and memory operations
package lsu_pkg;

  // register and load/store data width
  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;

  // encoded as log2 of the byte count
  typedef enum logic [1:0] {
    size_b = 2'd0, // 1 byte
    size_h = 2'd1, // 2 bytes
    size_w = 2'd2, // 4 bytes
    size_d = 2'd3  // 8 bytes
  } acc_size_e;

  // operation held by the stage while a bus transaction runs
  typedef enum logic [1:0] {
    op_none  = 2'd0,
    op_load  = 2'd1,
    op_store = 2'd2
  } mem_op_e;

endpackage

// File: verilog/mem_stage.sv
// memory access stage: captures one load or store and runs it over the data bus
`timescale 1ns/1ps

module mem_stage (
  input  logic               clk,
  input  logic               arst_n_i,
  // pipeline side
  input  logic               load_i,
  input  dbus_pkg::strb_t    store_mask_i,
  input  dbus_pkg::addr_t    addr_i,
  input  lsu_pkg::xlen_t     wdata_i,
  input  lsu_pkg::acc_size_e size_i,
  input  logic               sext_i,
  output logic               stall_o,
  output lsu_pkg::xlen_t     rdata_o,
  output logic               rdata_valid_o,
  // write channel
  output logic               w_req_valid_o,
  input  logic               w_req_ready_i,
  output dbus_pkg::addr_t    w_addr_o,
  output lsu_pkg::xlen_t     w_data_o,
  output dbus_pkg::strb_t    w_strb_o,
  input  logic               w_resp_valid_i,
  output logic               w_resp_ready_o,
  // read channel
  output logic               r_req_valid_o,
  input  logic               r_req_ready_i,
  output dbus_pkg::addr_t    r_addr_o,
  input  logic               r_resp_valid_i,
  input  lsu_pkg::xlen_t     r_data_i,
  output logic               r_resp_ready_o
);

  typedef enum logic {
    ph_req  = 1'b0, // request valid on the bus
    ph_resp = 1'b1  // request accepted, waiting for the response
  } phase_e;

  logic               stall_q;
  lsu_pkg::mem_op_e   op_q;
  phase_e             phase_q;
  logic               rdata_valid_q;
  dbus_pkg::addr_t    addr_q;
  lsu_pkg::xlen_t     wdata_q;
  lsu_pkg::acc_size_e size_q;
  logic               sext_q;
  lsu_pkg::xlen_t     rdata_q;
  lsu_pkg::xlen_t     load_ext;
  logic               take_store;
  logic               take_load;
  logic               req_fire;
  logic               resp_fire;

  // store wins when both arrive together
  assign take_store = !stall_q && (store_mask_i != '0);
  assign take_load  = !stall_q && load_i && (store_mask_i == '0);

  assign req_fire  = (w_req_valid_o && w_req_ready_i) || (r_req_valid_o && r_req_ready_i);
  assign resp_fire = (w_resp_valid_i && w_resp_ready_o) || (r_resp_valid_i && r_resp_ready_o);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stall_q       <= 1'b0;
      op_q          <= lsu_pkg::op_none;
      phase_q       <= ph_req;
      rdata_valid_q <= 1'b0;
    end else begin
      rdata_valid_q <= 1'b0;
      if (take_store || take_load) begin
        stall_q <= 1'b1;
        op_q    <= take_store ? lsu_pkg::op_store : lsu_pkg::op_load;
        phase_q <= ph_req;
      end else if (req_fire) begin
        phase_q <= ph_resp;
      end else if (resp_fire) begin
        stall_q       <= 1'b0;
        op_q          <= lsu_pkg::op_none;
        phase_q       <= ph_req;
        rdata_valid_q <= (op_q == lsu_pkg::op_load); // no pulse for stores
      end
    end
  end

  // request payload, held stable for the whole transaction
  always_ff @(posedge clk) begin
    if (take_store || take_load) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      size_q  <= size_i;
      sext_q  <= sext_i;
    end
    if (r_resp_valid_i && r_resp_ready_o) begin
      rdata_q <= load_ext;
    end
  end

  store_align u_store_align (
    .addr_lo_i (addr_q[2:0]),
    .wdata_i   (wdata_q),
    .size_i    (size_q),
    .data_o    (w_data_o),
    .strb_o    (w_strb_o)
  );

  load_align u_load_align (
    .addr_lo_i (addr_q[2:0]),
    .word_i    (r_data_i),
    .size_i    (size_q),
    .sext_i    (sext_q),
    .data_o    (load_ext)
  );

  assign stall_o       = stall_q;
  assign rdata_o       = rdata_q;
  assign rdata_valid_o = rdata_valid_q;

  assign w_req_valid_o  = (op_q == lsu_pkg::op_store) && (phase_q == ph_req);
  assign w_resp_ready_o = (op_q == lsu_pkg::op_store) && (phase_q == ph_resp);
  assign w_addr_o       = addr_q;
  assign r_req_valid_o  = (op_q == lsu_pkg::op_load) && (phase_q == ph_req);
  assign r_resp_ready_o = (op_q == lsu_pkg::op_load) && (phase_q == ph_resp);
  assign r_addr_o       = addr_q;

  // a pending request holds valid and payload until the slave takes it
  req_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    (w_req_valid_o && !w_req_ready_i) || (r_req_valid_o && !r_req_ready_i)
    |=> (w_req_valid_o || r_req_valid_o) && $stable(addr_q) && $stable(w_strb_o));

  // a new bus request only follows capture from an idle stage
  no_issue_busy_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(w_req_valid_o || r_req_valid_o) |-> $past(!stall_o));

  stall_cover_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    (w_req_valid_o || r_req_valid_o || w_resp_ready_o || r_resp_ready_o) |-> stall_o);

endmodule

// File: verilog/mem_subsys_top.sv
// memory subsystem: memory access stage connected to the data RAM slave
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               load_i,
  input  dbus_pkg::strb_t    store_mask_i,
  input  dbus_pkg::addr_t    addr_i,
  input  lsu_pkg::xlen_t     wdata_i,
  input  lsu_pkg::acc_size_e size_i,
  input  logic               sext_i,
  output logic               stall_o,
  output lsu_pkg::xlen_t     rdata_o,
  output logic               rdata_valid_o
);

  // write channel
  logic            w_req_valid;
  logic            w_req_ready;
  dbus_pkg::addr_t w_addr;
  lsu_pkg::xlen_t  w_data;
  dbus_pkg::strb_t w_strb;
  logic            w_resp_valid;
  logic            w_resp_ready;
  // read channel
  logic            r_req_valid;
  logic            r_req_ready;
  dbus_pkg::addr_t r_addr;
  logic            r_resp_valid;
  lsu_pkg::xlen_t  r_data;
  logic            r_resp_ready;

  mem_stage u_mem_stage (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .load_i         (load_i),
    .store_mask_i   (store_mask_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .size_i         (size_i),
    .sext_i         (sext_i),
    .stall_o        (stall_o),
    .rdata_o        (rdata_o),
    .rdata_valid_o  (rdata_valid_o),
    .w_req_valid_o  (w_req_valid),
    .w_req_ready_i  (w_req_ready),
    .w_addr_o       (w_addr),
    .w_data_o       (w_data),
    .w_strb_o       (w_strb),
    .w_resp_valid_i (w_resp_valid),
    .w_resp_ready_o (w_resp_ready),
    .r_req_valid_o  (r_req_valid),
    .r_req_ready_i  (r_req_ready),
    .r_addr_o       (r_addr),
    .r_resp_valid_i (r_resp_valid),
    .r_data_i       (r_data),
    .r_resp_ready_o (r_resp_ready)
  );

  data_ram #(
    .RAM_WORDS  (RAM_WORDS),
    .RESP_DELAY (RESP_DELAY)
  ) u_data_ram (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .w_req_valid_i  (w_req_valid),
    .w_req_ready_o  (w_req_ready),
    .w_addr_i       (w_addr),
    .w_data_i       (w_data),
    .w_strb_i       (w_strb),
    .w_resp_valid_o (w_resp_valid),
    .w_resp_ready_i (w_resp_ready),
    .r_req_valid_i  (r_req_valid),
    .r_req_ready_o  (r_req_ready),
    .r_addr_i       (r_addr),
    .r_resp_valid_o (r_resp_valid),
    .r_data_o       (r_data),
    .r_resp_ready_i (r_resp_ready)
  );

endmodule

// File: verilog/store_align.sv
// store lane placement: moves store data and byte strobe to the addressed lanes
`timescale 1ns/1ps

module store_align (
  input  logic [2:0]         addr_lo_i,
  input  lsu_pkg::xlen_t     wdata_i,
  input  lsu_pkg::acc_size_e size_i,
  output lsu_pkg::xlen_t     data_o,
  output dbus_pkg::strb_t    strb_o
);

  dbus_pkg::strb_t base_strb;
  logic [5:0]      bit_shift;
  logic [2:0]      off_mask;

  // strobe for the access at lane 0
  always_comb begin
    unique case (size_i)
      lsu_pkg::size_b: base_strb = 8'h01;
      lsu_pkg::size_h: base_strb = 8'h03;
      lsu_pkg::size_w: base_strb = 8'h0f;
      default:         base_strb = 8'hff;
    endcase
  end

  assign bit_shift = {addr_lo_i, 3'b000}; // bytes to bits
  assign strb_o    = base_strb << addr_lo_i;
  assign data_o    = wdata_i << bit_shift;

  // low offset bits that must be clear for a naturally aligned access
  assign off_mask = 3'((4'd1 << size_i) - 4'd1);

  // captured offset must be a multiple of the access size
  misaligned_a: assert final ($isunknown({addr_lo_i, size_i}) || (addr_lo_i & off_mask) == 3'd0)
    else $error("misaligned access offset %0d size %s", addr_lo_i, size_i.name());

endmodule
